// ==== hdl/uart_pkg.sv ====
`default_nettype none

package uart_pkg;

  typedef logic [7:0] byte_t;
  typedef logic [5:0] addr_t;
  typedef logic [7:0] count_t;
  typedef logic [3:0] bit_cnt_t;

  localparam int MEM_DEPTH = 1 << $bits(addr_t);        // 64 byte buffer

  localparam int DIV_RATE = 15;                          // divider reload
  localparam int BIT_TIME = DIV_RATE + 1;                // clocks per serial bit
  typedef logic [$clog2(BIT_TIME)-1:0] div_cnt_t;

  localparam addr_t RX_BASE = 6'd32;                     // receive region 32..63
  localparam int    RX_SIZE = 32;

  localparam int NUM_REQ = 3;                            // host, fetch, store

  localparam logic START_BIT = 1'b0;
  localparam logic STOP_BIT  = 1'b1;

  localparam bit_cnt_t BIT_CNT_MSB  = 4'd7;              // last data bit index
  localparam bit_cnt_t BIT_CNT_STOP = 4'd8;
  localparam bit_cnt_t BIT_CNT_DONE = 4'd9;

  // order also sets the grant vector bit positions
  typedef enum logic [1:0] {REQ_HOST, REQ_FETCH, REQ_STORE} req_id_t;

  typedef enum logic {TX_IDLE, TX_SEND} tx_state_t;

endpackage

`default_nettype wire

// ==== hdl/mem_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface mem_if (
  input wire clk
);

  logic            req;                                  // held until grant
  logic            we;
  uart_pkg::addr_t addr;
  uart_pkg::byte_t wdata;
  logic            grant;                                // one cycle pulse
  uart_pkg::byte_t rdata;                                // valid cycle after grant

  modport requester (
    input  clk, grant, rdata,
    output req, we, addr, wdata
  );

  modport arbiter (
    input  clk, req, we, addr, wdata,
    output grant, rdata
  );

endinterface

`default_nettype wire

// ==== hdl/uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
  input  wire                  clk,
  input  wire                  reset,
  input  wire                  uart_start,
  input  wire uart_pkg::byte_t uart_data,
  output logic                 uart_busy,
  output logic                 tx_end,
  output logic                 txd
);

  uart_pkg::tx_state_t state;
  uart_pkg::div_cnt_t  div_cnt;
  uart_pkg::bit_cnt_t  bit_cnt;
  uart_pkg::byte_t     sh_reg;
  logic                bit_tick;

  assign uart_busy = (state == uart_pkg::TX_SEND);
  assign bit_tick  = uart_busy && (div_cnt == '0);       // end of current bit

  always_ff @(posedge clk or negedge reset)
  begin
    if (!reset)
    begin
      state   <= uart_pkg::TX_IDLE;
      div_cnt <= uart_pkg::div_cnt_t'(uart_pkg::DIV_RATE);
      bit_cnt <= '0;
      tx_end  <= 1'b0;
      txd     <= uart_pkg::STOP_BIT;
    end
    else
    begin
      tx_end <= 1'b0;
      case (state)
        uart_pkg::TX_IDLE:
        begin
          if (uart_start)
          begin
            state   <= uart_pkg::TX_SEND;
            bit_cnt <= '0;
            txd     <= uart_pkg::START_BIT;
          end
        end
        uart_pkg::TX_SEND:
        begin
          if (bit_tick)
          begin
            div_cnt <= uart_pkg::div_cnt_t'(uart_pkg::DIV_RATE);
            case (bit_cnt)
              uart_pkg::BIT_CNT_STOP:
              begin
                txd     <= uart_pkg::STOP_BIT;
                bit_cnt <= uart_pkg::BIT_CNT_DONE;
              end
              uart_pkg::BIT_CNT_DONE:
              begin
                state  <= uart_pkg::TX_IDLE;            // stop bit finished
                tx_end <= 1'b1;
              end
              default:
              begin
                txd     <= sh_reg[0];                   // lsb first
                bit_cnt <= bit_cnt + 1'b1;
              end
            endcase
          end
          else
          begin
            div_cnt <= div_cnt - 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (!uart_busy && uart_start)
      sh_reg <= uart_data;
    else if (bit_tick && bit_cnt < uart_pkg::BIT_CNT_STOP)
      sh_reg <= sh_reg >> 1;
  end

endmodule

`default_nettype wire

// ==== hdl/uart_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
  input  wire             clk,
  input  wire             reset,
  input  wire             rxd,
  output uart_pkg::byte_t rx_data,
  output logic            rx_end,
  output logic            rx_error
);

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

  rx_state_t          state;
  logic               rxd_s1;
  logic               rxd_s2;
  logic               rxd_s3;
  logic               fall;
  uart_pkg::div_cnt_t cnt;
  uart_pkg::bit_cnt_t bit_cnt;
  uart_pkg::byte_t    sh_reg;

  assign fall    = rxd_s3 & ~rxd_s2;                    // start bit edge
  assign rx_data = sh_reg;

  always_ff @(posedge clk or negedge reset)
  begin
    if (!reset)
    begin
      rxd_s1 <= 1'b1;
      rxd_s2 <= 1'b1;
      rxd_s3 <= 1'b1;
    end
    else
    begin
      rxd_s1 <= rxd;
      rxd_s2 <= rxd_s1;
      rxd_s3 <= rxd_s2;
    end
  end

  always_ff @(posedge clk or negedge reset)
  begin
    if (!reset)
    begin
      state    <= RX_IDLE;
      cnt      <= '0;
      bit_cnt  <= '0;
      rx_end   <= 1'b0;
      rx_error <= 1'b0;
    end
    else
    begin
      rx_end   <= 1'b0;
      rx_error <= 1'b0;
      if (state != RX_IDLE && cnt != '0)
        cnt <= cnt - 1'b1;
      case (state)
        RX_IDLE:
        begin
          if (fall)
          begin
            cnt   <= uart_pkg::div_cnt_t'(uart_pkg::BIT_TIME / 2 - 1);  // half bit
            state <= RX_START;
          end
        end
        RX_START:
        begin
          if (cnt == '0)
          begin
            if (rxd_s2 == uart_pkg::START_BIT)
            begin
              cnt     <= uart_pkg::div_cnt_t'(uart_pkg::BIT_TIME - 1);
              bit_cnt <= '0;
              state   <= RX_DATA;
            end
            else
              state <= RX_IDLE;                         // glitch, not a start bit
          end
        end
        RX_DATA:
        begin
          if (cnt == '0)
          begin
            cnt <= uart_pkg::div_cnt_t'(uart_pkg::BIT_TIME - 1);
            if (bit_cnt == uart_pkg::BIT_CNT_MSB)
              state <= RX_STOP;
            else
              bit_cnt <= bit_cnt + 1'b1;
          end
        end
        RX_STOP:
        begin
          if (cnt == '0)
          begin
            if (rxd_s2 == uart_pkg::STOP_BIT)
              rx_end <= 1'b1;
            else
              rx_error <= 1'b1;                         // framing error
            state <= RX_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == RX_DATA && cnt == '0)
      sh_reg <= {rxd_s2, sh_reg[7:1]};                  // lsb arrives first
  end

endmodule

`default_nettype wire

// ==== hdl/tx_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module tx_fetch (
  input  wire                   clk,
  input  wire                   reset,
  input  wire                   tx_start,
  input  wire uart_pkg::addr_t  tx_base,
  input  wire uart_pkg::count_t tx_count,
  output logic                  tx_busy,
  output logic                  tx_done,
  mem_if.requester              bus,
  output logic                  uart_start,
  output uart_pkg::byte_t       uart_data,
  input  wire                   uart_busy,
  input  wire                   tx_end
);

  typedef enum logic [1:0] {F_IDLE, F_READ, F_LOAD, F_WAIT} fetch_state_t;

  fetch_state_t     state;
  uart_pkg::addr_t  addr;
  uart_pkg::count_t remain;

  assign tx_busy   = (state != F_IDLE);
  assign bus.req   = (state == F_READ);
  assign bus.we    = 1'b0;                                // read only peer
  assign bus.addr  = addr;
  assign bus.wdata = '0;

  always_ff @(posedge clk or negedge reset)
  begin
    if (!reset)
    begin
      state      <= F_IDLE;
      addr       <= '0;
      remain     <= '0;
      tx_done    <= 1'b0;
      uart_start <= 1'b0;
    end
    else
    begin
      tx_done    <= 1'b0;
      uart_start <= 1'b0;
      case (state)
        F_IDLE:
        begin
          if (tx_start)
          begin
            addr   <= tx_base;
            remain <= tx_count;
            if (tx_count == '0)
              tx_done <= 1'b1;                          // empty run
            else
              state <= F_READ;
          end
        end
        F_READ:
          if (bus.grant)
            state <= F_LOAD;
        F_LOAD:
        begin
          if (!uart_busy)
          begin
            uart_start <= 1'b1;
            state      <= F_WAIT;
          end
        end
        F_WAIT:
        begin
          if (tx_end)
          begin
            addr   <= addr + 1'b1;                      // wraps at 64
            remain <= remain - 1'b1;
            if (remain == 8'd1)
            begin
              tx_done <= 1'b1;
              state   <= F_IDLE;
            end
            else
              state <= F_READ;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == F_LOAD)
      uart_data <= bus.rdata;                           // rdata valid now
  end

endmodule

`default_nettype wire

// ==== hdl/rx_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_store (
  input  wire                  clk,
  input  wire                  reset,
  input  wire uart_pkg::byte_t rx_data,
  input  wire                  rx_end,
  mem_if.requester             bus,
  output uart_pkg::count_t     rx_count
);

  logic [$clog2(uart_pkg::RX_SIZE)-1:0] ptr;
  logic                                 req_q;
  uart_pkg::byte_t                      data_q;

  assign bus.req   = req_q;
  assign bus.we    = 1'b1;
  assign bus.addr  = uart_pkg::RX_BASE + uart_pkg::addr_t'(ptr);
  assign bus.wdata = data_q;

  always_ff @(posedge clk or negedge reset)
  begin
    if (!reset)
    begin
      ptr      <= '0;
      req_q    <= 1'b0;
      rx_count <= '0;
    end
    else
    begin
      if (bus.grant)
      begin
        req_q    <= 1'b0;
        rx_count <= rx_count + 1'b1;                    // free running
        if (int'(ptr) == uart_pkg::RX_SIZE - 1)
          ptr <= '0;
        else
          ptr <= ptr + 1'b1;
      end
      if (rx_end)
        req_q <= 1'b1;                                  // hold until grant
    end
  end

  always_ff @(posedge clk)
  begin
    if (rx_end)
      data_q <= rx_data;
  end

endmodule

`default_nettype wire

// ==== hdl/buffer_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module buffer_arbiter (
  input wire     clk,
  input wire     reset,
  mem_if.arbiter host,
  mem_if.arbiter fetch,
  mem_if.arbiter store
);

  uart_pkg::byte_t              mem [uart_pkg::MEM_DEPTH];
  uart_pkg::req_id_t            last;
  uart_pkg::req_id_t            pick_id;
  logic                         pick_valid;
  logic [uart_pkg::NUM_REQ-1:0] req_vec;
  logic [uart_pkg::NUM_REQ-1:0] grant_q;
  logic                         sel_we;
  uart_pkg::addr_t              sel_addr;
  uart_pkg::byte_t              sel_wdata;
  uart_pkg::byte_t              rd_q;

  assign req_vec[uart_pkg::REQ_HOST]  = host.req;
  assign req_vec[uart_pkg::REQ_FETCH] = fetch.req;
  assign req_vec[uart_pkg::REQ_STORE] = store.req;

  assign host.grant  = grant_q[uart_pkg::REQ_HOST];
  assign fetch.grant = grant_q[uart_pkg::REQ_FETCH];
  assign store.grant = grant_q[uart_pkg::REQ_STORE];

  assign host.rdata  = rd_q;
  assign fetch.rdata = rd_q;
  assign store.rdata = rd_q;

  // rotate from the peer after the last grant, skip the one in its grant cycle
  always_comb
  begin
    int idx;
    pick_valid = 1'b0;
    pick_id    = last;
    for (int k = 1; k <= uart_pkg::NUM_REQ; k++)
    begin
      idx = (int'(last) + k) % uart_pkg::NUM_REQ;
      if (!pick_valid && req_vec[idx] && !grant_q[idx])
      begin
        pick_valid = 1'b1;
        pick_id    = uart_pkg::req_id_t'(idx);
      end
    end
  end

  always_comb
  begin
    sel_we    = host.we & grant_q[uart_pkg::REQ_HOST];
    sel_addr  = host.addr;
    sel_wdata = host.wdata;
    if (grant_q[uart_pkg::REQ_FETCH])
    begin
      sel_we   = fetch.we;
      sel_addr = fetch.addr;
    end
    else if (grant_q[uart_pkg::REQ_STORE])
    begin
      sel_we    = store.we;
      sel_addr  = store.addr;
      sel_wdata = store.wdata;
    end
  end

  always_ff @(posedge clk or negedge reset)
  begin
    if (!reset)
    begin
      grant_q <= '0;
      last    <= uart_pkg::REQ_STORE;                   // host first after reset
    end
    else
    begin
      grant_q <= '0;
      if (pick_valid)
      begin
        grant_q[pick_id] <= 1'b1;
        last             <= pick_id;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (|grant_q)
    begin
      if (sel_we)
        mem[sel_addr] <= sel_wdata;
      rd_q <= mem[sel_addr];                            // old data on a write
    end
  end

endmodule

`default_nettype wire

// ==== hdl/uart_dma_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_dma_top (
  input  wire                   clk,
  input  wire                   reset,
  input  wire                   host_req,
  input  wire                   host_we,
  input  wire uart_pkg::addr_t  host_addr,
  input  wire uart_pkg::byte_t  host_wdata,
  output logic                  host_grant,
  output uart_pkg::byte_t       host_rdata,
  input  wire                   tx_start,
  input  wire uart_pkg::addr_t  tx_base,
  input  wire uart_pkg::count_t tx_count,
  output logic                  tx_busy,
  output logic                  tx_done,
  output uart_pkg::count_t      rx_count,
  output logic                  rx_error,
  output logic                  txd,
  input  wire                   rxd
);

  logic            uart_start;
  uart_pkg::byte_t uart_data;
  logic            uart_busy;
  logic            tx_end;
  uart_pkg::byte_t rx_data;
  logic            rx_end;

  mem_if host_bus  (.clk(clk));
  mem_if fetch_bus (.clk(clk));
  mem_if store_bus (.clk(clk));

  assign host_bus.req   = host_req;                    // host port straight onto bus
  assign host_bus.we    = host_we;
  assign host_bus.addr  = host_addr;
  assign host_bus.wdata = host_wdata;
  assign host_grant     = host_bus.grant;
  assign host_rdata     = host_bus.rdata;

  buffer_arbiter buffer_arbiter_i (
    .clk   (clk),
    .reset (reset),
    .host  (host_bus),
    .fetch (fetch_bus),
    .store (store_bus)
  );

  tx_fetch tx_fetch_i (
    .clk        (clk),
    .reset      (reset),
    .tx_start   (tx_start),
    .tx_base    (tx_base),
    .tx_count   (tx_count),
    .tx_busy    (tx_busy),
    .tx_done    (tx_done),
    .bus        (fetch_bus),
    .uart_start (uart_start),
    .uart_data  (uart_data),
    .uart_busy  (uart_busy),
    .tx_end     (tx_end)
  );

  uart_tx uart_tx_i (
    .clk        (clk),
    .reset      (reset),
    .uart_start (uart_start),
    .uart_data  (uart_data),
    .uart_busy  (uart_busy),
    .tx_end     (tx_end),
    .txd        (txd)
  );

  uart_rx uart_rx_i (
    .clk      (clk),
    .reset    (reset),
    .rxd      (rxd),
    .rx_data  (rx_data),
    .rx_end   (rx_end),
    .rx_error (rx_error)
  );

  rx_store rx_store_i (
    .clk      (clk),
    .reset    (reset),
    .rx_data  (rx_data),
    .rx_end   (rx_end),
    .bus      (store_bus),
    .rx_count (rx_count)
  );

endmodule

`default_nettype wire

// ==== bench/uart_dma_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_dma_sva (
  input wire                         clk,
  input wire                         reset,
  input wire [uart_pkg::NUM_REQ-1:0] req,
  input wire [uart_pkg::NUM_REQ-1:0] grant,
  input wire                         tx_idle,
  input wire                         txd
);

  a_one_grant: assert property (@(posedge clk) disable iff (!reset) $onehot0(grant))
    else $error("more than one grant in a cycle");

  a_grant_req: assert property (@(posedge clk) disable iff (!reset) (grant & ~req) == '0)
    else $error("grant to a peer that is not requesting");

  // sampled grant lands one to three edges after the request is seen
  for (genvar i = 0; i < uart_pkg::NUM_REQ; i++)
  begin : g_latency
    a_grant_latency: assert property (@(posedge clk) disable iff (!reset)
      $rose(req[i]) |-> ##3 ($past(grant[i], 2) || $past(grant[i], 1) || grant[i]))
      else $error("request %0d not granted within 3 cycles", i);
  end

  a_txd_idle: assert property (@(posedge clk) disable iff (!reset) tx_idle |-> txd)
    else $error("txd low while transmitter idle");

endmodule

bind buffer_arbiter uart_dma_sva arb_sva_i (
  .clk     (clk),
  .reset   (reset),
  .req     (req_vec),
  .grant   (grant_q),
  .tx_idle (1'b0),
  .txd     (1'b1)
);

bind uart_tx uart_dma_sva tx_sva_i (
  .clk     (clk),
  .reset   (reset),
  .req     ({uart_pkg::NUM_REQ{1'b0}}),
  .grant   ({uart_pkg::NUM_REQ{1'b0}}),
  .tx_idle (!uart_busy),
  .txd     (txd)
);

`default_nettype wire

// ==== bench/uart_dma_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_dma_tb;

  localparam int TIMEOUT = 5000;                        // clocks per wait

  logic                   clk = 1'b0;
  logic                   reset;
  logic                   host_req;
  logic                   host_we;
  uart_pkg::addr_t        host_addr;
  uart_pkg::byte_t        host_wdata;
  logic                   host_grant;
  uart_pkg::byte_t        host_rdata;
  logic                   tx_start;
  uart_pkg::addr_t        tx_base;
  uart_pkg::count_t       tx_count;
  logic                   tx_busy;
  logic                   tx_done;
  uart_pkg::count_t       rx_count;
  logic                   rx_error;
  logic                   txd;
  logic                   rxd;

  uart_pkg::byte_t        model_mem [uart_pkg::MEM_DEPTH];
  uart_pkg::byte_t        mon_q [$];                    // bytes seen on txd
  uart_pkg::byte_t        mon_shift;
  logic                   mon_active;
  int                     mon_cnt;
  int                     mon_bit;
  int                     rx_total;                     // good frames since reset
  int                     done_pulses;
  int                     err_pulses;
  int                     errors;
  int                     checks;
  int                     tests;
  int                     failed_tests;

  always #20 clk = ~clk;

  uart_dma_top uart_dma_top_i (.*);

  task automatic check_byte(input string name, input uart_pkg::byte_t got,
                            input uart_pkg::byte_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input uart_pkg::count_t got,
                             input uart_pkg::count_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic report_problem(input string msg);
    errors++;
    $display("ERROR: %s", msg);
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests++;
    if (errors != err_before)
      failed_tests++;
    $display("test %0d %s: %s", tests, name, (errors == err_before) ? "ok" : "failed");
  endtask

  // one host access with rdata taken the cycle after grant
  task automatic host_access(input logic we, input uart_pkg::addr_t addr,
                             input uart_pkg::byte_t wdata, output uart_pkg::byte_t rdata);
    int t;
    t = 0;
    @(posedge clk);
    host_req   <= 1'b1;
    host_we    <= we;
    host_addr  <= addr;
    host_wdata <= wdata;
    do
    begin
      @(negedge clk);
      t++;
    end while (host_grant !== 1'b1 && t < TIMEOUT);
    if (host_grant !== 1'b1)
      report_problem("host_grant never arrived");
    @(posedge clk);
    host_req <= 1'b0;
    host_we  <= 1'b0;
    @(negedge clk);
    rdata = host_rdata;
  endtask

  task automatic host_write(input uart_pkg::addr_t addr, input uart_pkg::byte_t data);
    uart_pkg::byte_t unused_rd;
    host_access(1'b1, addr, data, unused_rd);
    model_mem[addr] = data;
  endtask

  task automatic verify_read(input uart_pkg::addr_t addr);
    uart_pkg::byte_t rd;
    host_access(1'b0, addr, 8'h00, rd);
    check_byte($sformatf("host_rdata[%0d]", addr), rd, model_mem[addr]);
  endtask

  task automatic send_frame(input uart_pkg::byte_t data, input logic stop);
    logic [9:0] bits;
    bits = {stop, data, uart_pkg::START_BIT};           // lsb goes out first
    for (int i = 0; i < 11; i++)
    begin
      @(posedge clk);
      rxd <= (i < 10) ? bits[i] : 1'b1;                 // one idle bit after
      repeat (uart_pkg::BIT_TIME - 1) @(posedge clk);
    end
  endtask

  task automatic send_good_frame(input uart_pkg::byte_t data);
    send_frame(data, uart_pkg::STOP_BIT);
    model_mem[int'(uart_pkg::RX_BASE) + rx_total % uart_pkg::RX_SIZE] = data;
    rx_total++;
  endtask

  task automatic start_run(input int base, input int n);
    @(posedge clk);
    tx_start <= 1'b1;
    tx_base  <= uart_pkg::addr_t'(base);
    tx_count <= uart_pkg::count_t'(n);
    @(posedge clk);
    tx_start <= 1'b0;
    @(negedge clk);
    check_bit("tx_busy after tx_start", tx_busy, n != 0);
  endtask

  task automatic wait_tx_done(input int d0);
    int t;
    t = 0;
    while (done_pulses == d0 && t < TIMEOUT)
    begin
      @(negedge clk);
      t++;
    end
    if (done_pulses == d0)
      report_problem("tx_done did not arrive");
  endtask

  task automatic wait_rx_count(input uart_pkg::count_t exp);
    int t;
    t = 0;
    while (rx_count !== exp && t < TIMEOUT)
    begin
      @(negedge clk);
      t++;
    end
    check_count("rx_count", rx_count, exp);
  endtask

  task automatic compare_tx_bytes(input int base, input int n);
    check_count("monitor frames", uart_pkg::count_t'(mon_q.size()), uart_pkg::count_t'(n));
    for (int i = 0; i < n && i < mon_q.size(); i++)
      check_byte("txd byte", mon_q[i], model_mem[(base + i) % uart_pkg::MEM_DEPTH]);
  endtask

  // frame decoder sampling txd mid bit
  always @(negedge clk)
  begin
    if (reset !== 1'b1)
      mon_active = 1'b0;
    else if (!mon_active)
    begin
      if (txd === uart_pkg::START_BIT)
      begin
        mon_active = 1'b1;
        mon_cnt    = uart_pkg::BIT_TIME + uart_pkg::BIT_TIME / 2;  // first data centre
        mon_bit    = 0;
      end
    end
    else
    begin
      mon_cnt = mon_cnt - 1;
      if (mon_cnt == 0)
      begin
        mon_cnt = uart_pkg::BIT_TIME;
        if (mon_bit < 8)
          mon_shift = {txd, mon_shift[7:1]};
        else
        begin
          check_bit("txd stop bit", txd, uart_pkg::STOP_BIT);
          mon_q.push_back(mon_shift);
          mon_active = 1'b0;
        end
        mon_bit++;
      end
    end
  end

  // pulse counters see the values from before the edge
  always @(posedge clk)
  begin
    if (tx_done === 1'b1)
    begin
      done_pulses++;
      check_bit("tx_busy at tx_done", tx_busy, 1'b0);
    end
    if (rx_error === 1'b1)
      err_pulses++;
  end

  initial
  begin
    int e0;
    int n;
    int base;
    int d0;
    uart_pkg::count_t c0;
    errors = 0;
    checks = 0;
    tests = 0;
    failed_tests = 0;
    rx_total = 0;
    done_pulses = 0;
    err_pulses = 0;
    reset = 1'b0;
    host_req = 1'b0;
    host_we = 1'b0;
    host_addr = '0;
    host_wdata = '0;
    tx_start = 1'b0;
    tx_base = '0;
    tx_count = '0;
    rxd = 1'b1;
    void'($urandom(32'h8705));
    repeat (5) @(posedge clk);
    reset <= 1'b1;
    @(negedge clk);

    e0 = errors;
    check_bit("txd", txd, 1'b1);
    check_bit("tx_busy", tx_busy, 1'b0);
    check_bit("tx_done", tx_done, 1'b0);
    check_bit("host_grant", host_grant, 1'b0);
    check_bit("rx_error", rx_error, 1'b0);
    check_count("rx_count", rx_count, 8'd0);
    finish_test("reset state", e0);

    e0 = errors;
    for (int i = 0; i < 32; i++)
      host_write(uart_pkg::addr_t'(i), uart_pkg::byte_t'($urandom));
    for (int i = 0; i < 16; i++)
      verify_read(uart_pkg::addr_t'($urandom % 32));
    finish_test("host memory", e0);

    e0 = errors;
    n = 1 + $urandom % 6;
    base = $urandom % 64;                               // may wrap past 63
    for (int i = 0; i < n; i++)
      host_write(uart_pkg::addr_t'(base + i), uart_pkg::byte_t'($urandom));
    mon_q.delete();
    d0 = done_pulses;
    start_run(base, n);
    wait_tx_done(d0);
    repeat (uart_pkg::BIT_TIME) @(negedge clk);
    check_count("tx_done pulses", uart_pkg::count_t'(done_pulses - d0), 8'd1);
    compare_tx_bytes(base, n);
    finish_test("transmit run", e0);

    e0 = errors;
    n = 3 + $urandom % 4;
    for (int i = 0; i < n; i++)
      send_good_frame(uart_pkg::byte_t'($urandom));
    wait_rx_count(uart_pkg::count_t'(rx_total));
    for (int k = rx_total - n; k < rx_total; k++)
      verify_read(uart_pkg::addr_t'(int'(uart_pkg::RX_BASE) + k % uart_pkg::RX_SIZE));
    finish_test("receive", e0);

    e0 = errors;
    n = 1 + $urandom % 6;
    base = $urandom % (33 - n);                         // run stays in transmit half
    for (int i = 0; i < n; i++)
      host_write(uart_pkg::addr_t'(base + i), uart_pkg::byte_t'($urandom));
    mon_q.delete();
    d0 = done_pulses;
    fork
      begin
        start_run(base, n);
        wait_tx_done(d0);
      end
      begin
        for (int i = 0; i < 4; i++)
          send_good_frame(uart_pkg::byte_t'($urandom));
      end
      begin
        for (int i = 0; i < 12; i++)
        begin
          repeat ($urandom % 20) @(negedge clk);
          verify_read(uart_pkg::addr_t'($urandom % 32));
        end
      end
    join
    wait_rx_count(uart_pkg::count_t'(rx_total));
    compare_tx_bytes(base, n);
    for (int k = rx_total - 4; k < rx_total; k++)
      verify_read(uart_pkg::addr_t'(int'(uart_pkg::RX_BASE) + k % uart_pkg::RX_SIZE));
    finish_test("concurrency", e0);

    e0 = errors;
    c0 = rx_count;
    d0 = err_pulses;
    send_frame(uart_pkg::byte_t'($urandom), 1'b0);      // stop bit held low
    for (int t = 0; t < TIMEOUT && err_pulses == d0; t++)
      @(negedge clk);
    check_count("rx_error pulses", uart_pkg::count_t'(err_pulses - d0), 8'd1);
    check_count("rx_count after bad frame", rx_count, c0);
    send_good_frame(uart_pkg::byte_t'($urandom));
    wait_rx_count(c0 + 8'd1);
    verify_read(uart_pkg::addr_t'(int'(uart_pkg::RX_BASE) + (rx_total - 1) % uart_pkg::RX_SIZE));
    finish_test("framing error", e0);

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests, failed_tests, checks, errors);
    if (errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
hdl/uart_pkg.sv
hdl/mem_if.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/tx_fetch.sv
hdl/rx_store.sv
hdl/buffer_arbiter.sv
hdl/uart_dma_top.sv
bench/uart_dma_sva.sv
bench/uart_dma_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = uart_dma_tb
FILELIST = all.f
OBJ_DIR  = obj_dir
PASS_MSG = All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
